// File: rtl/fmul_params.svh
`ifndef FMUL_PARAMS_SVH
`define FMUL_PARAMS_SVH

// IEEE single precision word layout
`define FMUL_W        32
`define FMUL_EXP_W    8
`define FMUL_MAN_W    23
`define FMUL_BIAS     127

// significand split point
// the high part carries the hidden one, so HI + LO = MAN + 1
`define FMUL_LO_W     11
`define FMUL_HI_W     13

// clocks from a driven operand pair to its result on y and ovf
`define FMUL_LATENCY  3

`endif

// File: rtl/fmul_pkg.sv
`include "fmul_params.svh"

package fmul_pkg;

    // full single precision word
    typedef logic [`FMUL_W-1:0] float_t;

    // biased exponent and stored mantissa fields
    typedef logic [`FMUL_EXP_W-1:0] exp_t;
    typedef logic [`FMUL_MAN_W-1:0] man_t;

    // significand halves, the high one includes the hidden one
    typedef logic [`FMUL_HI_W-1:0] hi_t;
    typedef logic [`FMUL_LO_W-1:0] lo_t;

    // partial products
    typedef logic [2*`FMUL_HI_W-1:0] hh_t;
    typedef logic [`FMUL_HI_W+`FMUL_LO_W-1:0] cross_t;

    // truncated product sum, one bit wider than hh for the carry
    typedef logic [2*`FMUL_HI_W:0] msum_t;

    // exponent sum with two guard bits
    // bit 9 set is overflow, bit 8 clear is underflow
    typedef logic [`FMUL_EXP_W+1:0] wexp_t;

endpackage

// File: rtl/fmul_split.sv
`timescale 1ns/1ps
`include "fmul_params.svh"

module fmul_split (
    input  logic             clk,
    input  logic             rstn,
    input  fmul_pkg::float_t x1,
    input  fmul_pkg::float_t x2,
    output logic             s1,
    output logic             s2,
    output fmul_pkg::exp_t   e1,
    output fmul_pkg::exp_t   e2,
    output fmul_pkg::hi_t    hi1,
    output fmul_pkg::hi_t    hi2,
    output fmul_pkg::lo_t    lo1,
    output fmul_pkg::lo_t    lo2
);

    fmul_pkg::man_t m1;
    fmul_pkg::man_t m2;
    fmul_pkg::hi_t  hi1_c;
    fmul_pkg::hi_t  hi2_c;

    assign m1 = x1[`FMUL_MAN_W-1:0];
    assign m2 = x2[`FMUL_MAN_W-1:0];

    // hidden one on top of the upper mantissa bits
    assign hi1_c = {1'b1, m1[`FMUL_MAN_W-1:`FMUL_LO_W]};
    assign hi2_c = {1'b1, m2[`FMUL_MAN_W-1:`FMUL_LO_W]};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1  <= 1'b0;
            s2  <= 1'b0;
            e1  <= '0;
            e2  <= '0;
            hi1 <= '0;
            hi2 <= '0;
            lo1 <= '0;
            lo2 <= '0;
        end else begin
            s1  <= x1[`FMUL_W-1];
            s2  <= x2[`FMUL_W-1];
            e1  <= x1[`FMUL_W-2 -: `FMUL_EXP_W];
            e2  <= x2[`FMUL_W-2 -: `FMUL_EXP_W];
            hi1 <= hi1_c;
            hi2 <= hi2_c;
            lo1 <= m1[`FMUL_LO_W-1:0];
            lo2 <= m2[`FMUL_LO_W-1:0];
        end
    end

endmodule

// File: rtl/fmul_partial.sv
`timescale 1ns/1ps

module fmul_partial (
    input  logic             clk,
    input  logic             rstn,
    input  logic             s1,
    input  logic             s2,
    input  fmul_pkg::exp_t   e1,
    input  fmul_pkg::exp_t   e2,
    input  fmul_pkg::hi_t    hi1,
    input  fmul_pkg::hi_t    hi2,
    input  fmul_pkg::lo_t    lo1,
    input  fmul_pkg::lo_t    lo2,
    output fmul_pkg::hh_t    hh,
    output fmul_pkg::cross_t hl,
    output fmul_pkg::cross_t lh,
    output logic             s1_q,
    output logic             s2_q,
    output fmul_pkg::exp_t   e1_q,
    output fmul_pkg::exp_t   e2_q
);

    fmul_pkg::hh_t    hh_c;
    fmul_pkg::cross_t hl_c;
    fmul_pkg::cross_t lh_c;

    // three of the four partial products
    // low x low only touches bits below the kept window and is dropped
    assign hh_c = fmul_pkg::hh_t'(hi1) * fmul_pkg::hh_t'(hi2);
    assign hl_c = fmul_pkg::cross_t'(hi1) * fmul_pkg::cross_t'(lo2);
    assign lh_c = fmul_pkg::cross_t'(lo1) * fmul_pkg::cross_t'(hi2);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            hh   <= '0;
            hl   <= '0;
            lh   <= '0;
            s1_q <= 1'b0;
            s2_q <= 1'b0;
            e1_q <= '0;
            e2_q <= '0;
        end else begin
            hh   <= hh_c;
            hl   <= hl_c;
            lh   <= lh_c;
            // sign and exponent ride along with the products
            s1_q <= s1;
            s2_q <= s2;
            e1_q <= e1;
            e2_q <= e2;
        end
    end

endmodule

// File: rtl/fmul_merge.sv
`timescale 1ns/1ps
`include "fmul_params.svh"

module fmul_merge (
    input  logic             clk,
    input  logic             rstn,
    input  fmul_pkg::hh_t    hh,
    input  fmul_pkg::cross_t hl,
    input  fmul_pkg::cross_t lh,
    input  logic             s1,
    input  logic             s2,
    input  fmul_pkg::exp_t   e1,
    input  fmul_pkg::exp_t   e2,
    output logic             ys,
    output fmul_pkg::msum_t  msum,
    output fmul_pkg::man_t   ym0,
    output fmul_pkg::wexp_t  ye0,
    output logic             is_zero,
    output logic             is_inf
);

    localparam int MSB = 2 * `FMUL_HI_W;

    fmul_pkg::msum_t msum_c;
    fmul_pkg::man_t  ym0_c;
    fmul_pkg::wexp_t ye0_c;

    // cross products are aligned by dropping their low bits
    // +2 compensates on average for the missing low x low term
    assign msum_c = fmul_pkg::msum_t'(hh)
                  + fmul_pkg::msum_t'(hl >> `FMUL_LO_W)
                  + fmul_pkg::msum_t'(lh >> `FMUL_LO_W)
                  + fmul_pkg::msum_t'(2);

    // truncate: take the 23 bits right under the leading one
    always_comb begin
        if (msum_c[MSB]) begin
            ym0_c = msum_c[MSB-1 -: `FMUL_MAN_W];
        end else if (msum_c[MSB-1]) begin
            ym0_c = msum_c[MSB-2 -: `FMUL_MAN_W];
        end else if (msum_c[MSB-2]) begin
            ym0_c = msum_c[MSB-3 -: `FMUL_MAN_W];
        end else begin
            ym0_c = msum_c[`FMUL_MAN_W-1:0];
        end
    end

    // e1 + e2 - bias, offset by 256 so underflow shows as bit 8 clear
    assign ye0_c = fmul_pkg::wexp_t'(e1) + fmul_pkg::wexp_t'(e2)
                 + fmul_pkg::wexp_t'((1 << `FMUL_EXP_W) - `FMUL_BIAS);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ys      <= 1'b0;
            msum    <= '0;
            ym0     <= '0;
            ye0     <= '0;
            is_zero <= 1'b0;
            is_inf  <= 1'b0;
        end else begin
            ys      <= s1 ^ s2;
            msum    <= msum_c;
            ym0     <= ym0_c;
            ye0     <= ye0_c;
            // zero exponent also covers denormals, which are flushed
            is_zero <= ~(|e1) | ~(|e2);
            // all-ones exponent covers both infinity and NaN
            is_inf  <= (&e1) | (&e2);
        end
    end

endmodule

// File: rtl/fmul_pack.sv
`timescale 1ns/1ps
`include "fmul_params.svh"

module fmul_pack (
    input  logic             ys,
    input  fmul_pkg::msum_t  msum,
    input  fmul_pkg::man_t   ym0,
    input  fmul_pkg::wexp_t  ye0,
    input  logic             is_zero,
    input  logic             is_inf,
    output fmul_pkg::float_t y,
    output logic             ovf
);

    localparam int MSB = 2 * `FMUL_HI_W;

    logic [`FMUL_EXP_W:0] ye1;
    fmul_pkg::exp_t       ye;
    fmul_pkg::man_t       ym;

    // exponent after the normalization shift, saturate or flush first
    always_comb begin
        if (ye0[`FMUL_EXP_W+1]) begin
            ye1 = {1'b0, {`FMUL_EXP_W{1'b1}}};
        end else if (!ye0[`FMUL_EXP_W]) begin
            ye1 = '0;
        end else if (msum[MSB]) begin
            ye1 = {1'b0, ye0[`FMUL_EXP_W-1:0]} + 2'd2;
        end else if (msum[MSB-1]) begin
            ye1 = {1'b0, ye0[`FMUL_EXP_W-1:0]} + 2'd1;
        end else begin
            ye1 = {1'b0, ye0[`FMUL_EXP_W-1:0]};
        end
    end

    // carry out of the adjust also lands on infinity
    assign ye = ye1[`FMUL_EXP_W] ? {`FMUL_EXP_W{1'b1}} : ye1[`FMUL_EXP_W-1:0];

    // zero and infinity carry no mantissa
    assign ym = (&ye || ye == '0) ? '0 : ym0;

    always_comb begin
        if (is_zero) begin
            y = {ys, {(`FMUL_W-1){1'b0}}};
        end else if (is_inf) begin
            y = {ys, {`FMUL_EXP_W{1'b1}}, {`FMUL_MAN_W{1'b0}}};
        end else begin
            y = {ys, ye, ym};
        end
    end

    // taken from the stage-3 register so it matches its own result
    assign ovf = ye0[`FMUL_EXP_W+1];

endmodule

// File: rtl/fmul.sv
`timescale 1ns/1ps

module fmul (
    input  logic             clk,
    input  logic             rstn,
    input  fmul_pkg::float_t x1,
    input  fmul_pkg::float_t x2,
    output fmul_pkg::float_t y,
    output logic             ovf
);

    // stage 0 to stage 1
    logic             s1;
    logic             s2;
    fmul_pkg::exp_t   e1;
    fmul_pkg::exp_t   e2;
    fmul_pkg::hi_t    hi1;
    fmul_pkg::hi_t    hi2;
    fmul_pkg::lo_t    lo1;
    fmul_pkg::lo_t    lo2;

    // stage 1 to stage 2
    fmul_pkg::hh_t    hh;
    fmul_pkg::cross_t hl;
    fmul_pkg::cross_t lh;
    logic             s1_d;
    logic             s2_d;
    fmul_pkg::exp_t   e1_d;
    fmul_pkg::exp_t   e2_d;

    // stage 2 to output logic
    logic             ys;
    fmul_pkg::msum_t  msum;
    fmul_pkg::man_t   ym0;
    fmul_pkg::wexp_t  ye0;
    logic             is_zero;
    logic             is_inf;

    fmul_split u_split (
        .clk  (clk),
        .rstn (rstn),
        .x1   (x1),
        .x2   (x2),
        .s1   (s1),
        .s2   (s2),
        .e1   (e1),
        .e2   (e2),
        .hi1  (hi1),
        .hi2  (hi2),
        .lo1  (lo1),
        .lo2  (lo2)
    );

    fmul_partial u_partial (
        .clk  (clk),
        .rstn (rstn),
        .s1   (s1),
        .s2   (s2),
        .e1   (e1),
        .e2   (e2),
        .hi1  (hi1),
        .hi2  (hi2),
        .lo1  (lo1),
        .lo2  (lo2),
        .hh   (hh),
        .hl   (hl),
        .lh   (lh),
        .s1_q (s1_d),
        .s2_q (s2_d),
        .e1_q (e1_d),
        .e2_q (e2_d)
    );

    fmul_merge u_merge (
        .clk     (clk),
        .rstn    (rstn),
        .hh      (hh),
        .hl      (hl),
        .lh      (lh),
        .s1      (s1_d),
        .s2      (s2_d),
        .e1      (e1_d),
        .e2      (e2_d),
        .ys      (ys),
        .msum    (msum),
        .ym0     (ym0),
        .ye0     (ye0),
        .is_zero (is_zero),
        .is_inf  (is_inf)
    );

    fmul_pack u_pack (
        .ys      (ys),
        .msum    (msum),
        .ym0     (ym0),
        .ye0     (ye0),
        .is_zero (is_zero),
        .is_inf  (is_inf),
        .y       (y),
        .ovf     (ovf)
    );

endmodule

// File: verification/fmul_assert.sv
`timescale 1ns/1ps
`include "fmul_params.svh"

module fmul_assert (
    input logic             clk,
    input logic             rstn,
    input fmul_pkg::float_t y,
    input logic             ovf
);

    fmul_pkg::exp_t y_exp;
    fmul_pkg::man_t y_man;

    assign y_exp = y[`FMUL_W-2 -: `FMUL_EXP_W];
    assign y_man = y[`FMUL_MAN_W-1:0];

    // overflow always lands on a clean infinity
    ovf_gives_inf: assert property (
        @(posedge clk) disable iff (!rstn)
        ovf |-> (&y_exp) && (y_man == '0)
    ) else $error("ovf high while y is not an infinity");

    // NaN inputs come out as infinity, so no NaN pattern ever shows
    no_nan_out: assert property (
        @(posedge clk) disable iff (!rstn)
        !((&y_exp) && (y_man != '0))
    ) else $error("y carries a NaN pattern");

    reset_clears: assert property (
        @(posedge clk)
        !rstn |=> (y == '0) && !ovf
    ) else $error("y or ovf not cleared by reset");

    // first pair needs every stage before it reaches y
    empty_after_reset: assert property (
        @(posedge clk)
        $rose(rstn) |-> ((y == '0) && !ovf) [*`FMUL_LATENCY]
    ) else $error("result appeared before the pipeline filled");

endmodule

// File: verification/fmul_tb.sv
`timescale 1ns/1ps
`include "fmul_params.svh"

module fmul_tb;

    localparam int N_EXACT      = 4;
    localparam int N_SPECIAL    = 7;
    localparam int N_RANDOM     = 40;
    localparam int N_OVF        = 3;
    localparam int N_UNF        = 3;
    localparam int DRAIN_CYCLES = `FMUL_LATENCY + 2;
    localparam int RUN_CYCLES   = 5 + `FMUL_LATENCY + 1 + N_EXACT + N_SPECIAL + N_RANDOM
                                + N_OVF + N_UNF + 5 * DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

    logic             clk = 1'b0;
    logic             rstn;
    fmul_pkg::float_t x1;
    fmul_pkg::float_t x2;
    fmul_pkg::float_t y;
    logic             ovf;

    // falling edges seen so far
    int               cycle = 0;
    logic [31:0]      lfsr_state;

    // scoreboard holds one entry per driven pair
    int               due_q[$];
    fmul_pkg::float_t exp_y_q[$];
    logic             exp_ovf_q[$];

    fmul UUT (
        .clk  (clk),
        .rstn (rstn),
        .x1   (x1),
        .x2   (x2),
        .y    (y),
        .ovf  (ovf)
    );

    bind fmul fmul_assert u_assert (
        .clk  (clk),
        .rstn (rstn),
        .y    (y),
        .ovf  (ovf)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // right-shifting Galois form of x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        int          i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // exponent kept in 64..191 so both operands are normal
    function automatic fmul_pkg::float_t normal_operand();
        logic [31:0]    r_sign;
        logic [31:0]    r_exp;
        logic [31:0]    r_man;
        fmul_pkg::exp_t ex;
        r_sign = take_bits(1);
        r_exp  = take_bits(7);
        r_man  = take_bits(`FMUL_MAN_W);
        ex     = 8'd64 + r_exp[6:0];
        return {r_sign[0], ex, r_man[`FMUL_MAN_W-1:0]};
    endfunction

    // truncated split product and special cases modelled from the format rules
    function automatic fmul_pkg::float_t model_product(
        input  fmul_pkg::float_t a,
        input  fmul_pkg::float_t b,
        output logic             ovf_o
    );
        longint         ha;
        longint         la;
        longint         hb;
        longint         lb;
        longint         total;
        logic [26:0]    sum;
        logic [22:0]    man;
        int             ea;
        int             eb;
        int             biased;
        int             ex;
        logic           sgn;
        ea     = a[30:23];
        eb     = b[30:23];
        sgn    = a[31] ^ b[31];
        ha     = {1'b1, a[22:11]};
        la     = a[10:0];
        hb     = {1'b1, b[22:11]};
        lb     = b[10:0];
        total  = ha * hb + ((ha * lb) >> 11) + ((la * hb) >> 11) + 2;
        sum    = total[26:0];
        biased = ea + eb - `FMUL_BIAS;
        ovf_o  = (biased >= 256);
        if (sum[26]) begin
            man = sum[25:3];
        end else if (sum[25]) begin
            man = sum[24:2];
        end else if (sum[24]) begin
            man = sum[23:1];
        end else begin
            man = sum[22:0];
        end
        if (biased >= 256) begin
            ex = 255;
        end else if (biased < 0) begin
            ex = 0;
        end else begin
            ex = biased + (sum[26] ? 2 : (sum[25] ? 1 : 0));
        end
        if (ex > 255) begin
            ex = 255;
        end
        if (ex == 0 || ex == 255) begin
            man = '0;
        end
        if (ea == 0 || eb == 0) begin
            return {sgn, 31'h0};
        end else if (ea == 255 || eb == 255) begin
            return {sgn, 8'hFF, 23'h0};
        end
        return {sgn, ex[7:0], man};
    endfunction

    task automatic check_float(
        input string            name,
        input fmul_pkg::float_t got,
        input fmul_pkg::float_t want
    );
        if (got !== want) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, want);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_ovf(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, want);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic send_pair(
        input fmul_pkg::float_t a,
        input fmul_pkg::float_t b,
        input fmul_pkg::float_t want_y,
        input logic             want_ovf
    );
        @(posedge clk);
        x1 <= a;
        x2 <= b;
        // result settles LATENCY edges later and is read on the falling edge after
        due_q.push_back(cycle + `FMUL_LATENCY + 1);
        exp_y_q.push_back(want_y);
        exp_ovf_q.push_back(want_ovf);
    endtask

    task automatic random_pair();
        fmul_pkg::float_t a;
        fmul_pkg::float_t b;
        fmul_pkg::float_t want_y;
        logic             want_ovf;
        a      = normal_operand();
        b      = normal_operand();
        want_y = model_product(a, b, want_ovf);
        send_pair(a, b, want_y, want_ovf);
    endtask

    task automatic wait_drain();
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // compare results on the falling edge while y and ovf are stable
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            check_float("y", y, exp_y_q[0]);
            check_ovf("ovf", ovf, exp_ovf_q[0]);
            void'(due_q.pop_front());
            void'(exp_y_q.pop_front());
            void'(exp_ovf_q.pop_front());
        end
    end

    // operands of 3.0 and -5.0 are held through reset and must not leak out early
    task automatic reset_check();
        int i;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        for (i = 0; i < `FMUL_LATENCY; i++) begin
            @(negedge clk);
            check_float("y", y, 32'h0000_0000);
            check_ovf("ovf", ovf, 1'b0);
        end
        @(negedge clk);
        check_float("y", y, 32'hC170_0001);
        check_ovf("ovf", ovf, 1'b0);
    endtask

    // the +2 in the sum leaves one ulp on products whose low bits are all zero
    task automatic exact_products();
        send_pair(32'h3F80_0000, 32'h3F80_0000, 32'h3F80_0001, 1'b0);
        send_pair(32'h4000_0000, 32'h4040_0000, 32'h40C0_0001, 1'b0);
        send_pair(32'hBFC0_0000, 32'h4080_0000, 32'hC0C0_0001, 1'b0);
        send_pair(32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000, 1'b0);
        wait_drain();
    endtask

    task automatic zero_inf_cases();
        send_pair(32'h0000_0000, 32'h4040_0000, 32'h0000_0000, 1'b0);
        send_pair(32'h8000_0000, 32'h4040_0000, 32'h8000_0000, 1'b0);
        // denormal flushed
        send_pair(32'h0000_0123, 32'hC000_0000, 32'h8000_0000, 1'b0);
        // zero wins over infinity
        send_pair(32'h0000_0000, 32'h7F80_0000, 32'h0000_0000, 1'b0);
        send_pair(32'hFF80_0000, 32'h8000_0000, 32'h0000_0000, 1'b0);
        // exponent sum of infinity and 2.0 already passes the range
        send_pair(32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000, 1'b1);
        send_pair(32'h7FC0_0000, 32'h3F80_0000, 32'h7F80_0000, 1'b0);
        wait_drain();
    endtask

    task automatic random_burst();
        int i;
        for (i = 0; i < N_RANDOM; i++) begin
            random_pair();
        end
        wait_drain();
    endtask

    task automatic overflow_cases();
        send_pair(32'h7D00_0000, 32'h7D00_0000, 32'h7F80_0000, 1'b1);
        send_pair(32'hFD00_0000, 32'h7D00_0000, 32'hFF80_0000, 1'b1);
        // normalization carry from 254 to 255 saturates without the flag
        send_pair(32'h6440_0000, 32'h5AC0_0000, 32'h7F80_0000, 1'b0);
        wait_drain();
    endtask

    task automatic underflow_cases();
        send_pair(32'h0A00_0000, 32'h0A00_0000, 32'h0000_0000, 1'b0);
        send_pair(32'h8A00_0000, 32'h0A00_0000, 32'h8000_0000, 1'b0);
        // biased exponent lands exactly on 0
        send_pair(32'h1F80_0000, 32'h2000_0000, 32'h0000_0000, 1'b0);
        wait_drain();
    endtask

    initial begin
        rstn       = 1'b0;
        x1         = 32'h4040_0000;
        x2         = 32'hC0A0_0000;
        lfsr_state = 32'h9dab_8d2f;
        reset_check();
        exact_products();
        zero_inf_cases();
        random_burst();
        overflow_cases();
        underflow_cases();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: fmul.f
+incdir+rtl
rtl/fmul_pkg.sv
rtl/fmul_split.sv
rtl/fmul_partial.sv
rtl/fmul_merge.sv
rtl/fmul_pack.sv
rtl/fmul.sv
verification/fmul_assert.sv
verification/fmul_tb.sv
